//--- common/batchPkg.sv
`default_nettype none

package batchPkg;

    localparam int NUM_CHAN    = 3;
    localparam int BATCH_DEPTH = 16;
    localparam int NUM_BANKS   = 4;
    localparam int FRAC_BITS   = 12;
    // Cycles from sample read address to channel sum
    localparam int PIPE_LAT    = 3;

    typedef logic [NUM_CHAN-1:0] ctrlBitsT;
    typedef logic signed [15:0] fixT;
    typedef logic signed [15:0] estT;
    typedef logic [$clog2(BATCH_DEPTH)-1:0] sampleIdxT;
    typedef logic [$clog2(NUM_BANKS)-1:0] bankT;

    typedef struct packed {
        fixT re;
        fixT im;
    } complexT;

    typedef struct packed {
        bankT writeBank;
        bankT lookBank;
        bankT calcBank;
        logic prevCalcParity;
    } bankSelT;

    // Input terms, indexed [set][channel][control bit], set 0 backward and set 1 forward
    localparam fixT gammaRe [2][NUM_CHAN][NUM_CHAN] = '{
        '{'{16'sd512, -16'sd256, 16'sd128}, '{-16'sd384, 16'sd640, -16'sd192},
          '{16'sd256, 16'sd128, -16'sd448}},
        '{'{16'sd448, 16'sd192, -16'sd320}, '{-16'sd224, 16'sd576, 16'sd160},
          '{16'sd352, -16'sd96, 16'sd288}}
    };
    localparam fixT gammaIm [2][NUM_CHAN][NUM_CHAN] = '{
        '{'{16'sd96, -16'sd160, 16'sd64}, '{16'sd200, -16'sd72, 16'sd144},
          '{-16'sd120, 16'sd88, 16'sd176}},
        '{'{-16'sd80, 16'sd136, -16'sd48}, '{16'sd112, -16'sd184, 16'sd72},
          '{-16'sd152, 16'sd64, -16'sd96}}
    };

    // Backward and lookahead factors
    localparam fixT lambdaRe [NUM_CHAN] = '{16'sd3686, 16'sd3482, 16'sd3277};
    localparam fixT lambdaIm [NUM_CHAN] = '{16'sd410, -16'sd614, 16'sd819};
    // Forward factors
    localparam fixT phiRe [NUM_CHAN] = '{16'sd3891, 16'sd3584, 16'sd3379};
    localparam fixT phiIm [NUM_CHAN] = '{-16'sd205, 16'sd512, -16'sd717};

    localparam fixT weightFwdRe [NUM_CHAN] = '{16'sd2048, -16'sd1536, 16'sd1229};
    localparam fixT weightFwdIm [NUM_CHAN] = '{-16'sd819, 16'sd1024, -16'sd410};
    localparam fixT weightBwdRe [NUM_CHAN] = '{16'sd1843, 16'sd1331, -16'sd1024};
    localparam fixT weightBwdIm [NUM_CHAN] = '{16'sd614, -16'sd717, 16'sd922};

    // Full product, arithmetic shift, low 16 bits kept
    function automatic fixT fixMul(fixT a, fixT b);
        logic signed [31:0] prod;
        prod = a * b;
        return fixT'(prod >>> FRAC_BITS);
    endfunction

    function automatic complexT cMul(complexT a, complexT b);
        complexT res;
        res.re = fixMul(a.re, b.re) - fixMul(a.im, b.im);
        res.im = fixMul(a.re, b.im) + fixMul(a.im, b.re);
        return res;
    endfunction

    function automatic complexT cAdd(complexT a, complexT b);
        complexT res;
        res.re = a.re + b.re;
        res.im = a.im + b.im;
        return res;
    endfunction

endpackage

`default_nettype wire

//--- hw/batchCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module batchCtrl
    import batchPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output sampleIdxT sampleIdx,
    output sampleIdxT sampleIdxRev,
    output bankSelT   bankSel,
    output logic      batchStart,
    output logic      outEnable
);

    bankT       bankCnt;
    logic [2:0] startCnt;
    logic       lastSample;

    assign lastSample   = (sampleIdx == sampleIdxT'(BATCH_DEPTH - 1));
    assign sampleIdxRev = sampleIdxT'(BATCH_DEPTH - 1) - sampleIdx;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sampleIdx  <= '0;
            bankCnt    <= '0;
            startCnt   <= '0;
            batchStart <= 1'b0;
        end else begin
            sampleIdx  <= sampleIdx + sampleIdxT'(1);
            // Lines up with the read data of sample 0
            batchStart <= (sampleIdx == '0);
            if (lastSample) begin
                bankCnt <= bankCnt + bankT'(1);
                // Counts finished batches up to the first output batch
                if (startCnt != 3'(NUM_BANKS)) begin
                    startCnt <= startCnt + 3'd1;
                end
            end
        end
    end

    assign outEnable = (startCnt == 3'(NUM_BANKS));

    // Look bank one behind the write bank, calc bank three behind
    assign bankSel.writeBank      = bankCnt;
    assign bankSel.lookBank       = bankCnt - bankT'(1);
    assign bankSel.calcBank       = bankCnt - bankT'(NUM_BANKS - 1);
    assign bankSel.prevCalcParity = ~bankSel.calcBank[0];

    // Startup counter saturates, so output stays enabled until the next reset
    outStaysOn: assert property (@(posedge clk) disable iff (!rst)
        outEnable |=> outEnable)
        else $error("outEnable dropped without reset");

endmodule

`default_nettype wire

//--- hw/sampleRam.sv
`timescale 1ns/1ps
`default_nettype none

module sampleRam
    import batchPkg::*;
(
    input  logic      clk,
    input  ctrlBitsT  ctrlIn,
    input  bankSelT   bankSel,
    input  sampleIdxT sampleIdx,
    input  sampleIdxT sampleIdxRev,
    output ctrlBitsT  lookSample,
    output ctrlBitsT  calcFwdSample,
    output ctrlBitsT  calcBwdSample
);

    ctrlBitsT mem [NUM_BANKS * BATCH_DEPTH];

    logic [$clog2(NUM_BANKS * BATCH_DEPTH)-1:0] wrAddr;
    logic [$clog2(NUM_BANKS * BATCH_DEPTH)-1:0] lookAddr;
    logic [$clog2(NUM_BANKS * BATCH_DEPTH)-1:0] fwdAddr;
    logic [$clog2(NUM_BANKS * BATCH_DEPTH)-1:0] bwdAddr;

    // Bank number on top, sample index below
    assign wrAddr   = {bankSel.writeBank, sampleIdx};
    assign lookAddr = {bankSel.lookBank, sampleIdxRev};
    assign fwdAddr  = {bankSel.calcBank, sampleIdx};
    assign bwdAddr  = {bankSel.calcBank, sampleIdxRev};

    // One write and three reads every cycle
    always_ff @(posedge clk) begin
        mem[wrAddr]   <= ctrlIn;
        lookSample    <= mem[lookAddr];
        calcFwdSample <= mem[fwdAddr];
        calcBwdSample <= mem[bwdAddr];
    end

endmodule

`default_nettype wire

//--- hw/coeffLut.sv
`timescale 1ns/1ps
`default_nettype none

module coeffLut
    import batchPkg::*;
#(
    parameter int chanIdx    = 0,
    parameter bit useForward = 1'b0
) (
    input  ctrlBitsT bits,
    output complexT  term
);

    // Each control bit adds or subtracts its gamma
    always_comb begin
        term = '0;
        for (int b = 0; b < NUM_CHAN; b++) begin
            if (bits[b]) begin
                term.re = term.re + gammaRe[useForward][chanIdx][b];
                term.im = term.im + gammaIm[useForward][chanIdx][b];
            end else begin
                term.re = term.re - gammaRe[useForward][chanIdx][b];
                term.im = term.im - gammaIm[useForward][chanIdx][b];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/recursion.sv
`timescale 1ns/1ps
`default_nettype none

module recursion
    import batchPkg::*;
#(
    parameter fixT factorRe = '0,
    parameter fixT factorIm = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  complexT seed,
    input  complexT term,
    output complexT state
);

    complexT base;

    // Seed takes the place of the old state on a start step
    assign base = start ? seed : state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= '0;
        end else begin
            state <= cAdd(cMul(complexT'{factorRe, factorIm}, base), term);
        end
    end

    // Start steps are a whole batch apart
    startSpacing: assert property (@(posedge clk) disable iff (!rst)
        start |=> !start)
        else $error("back to back start steps");

endmodule

`default_nettype wire

//--- estimator/channelCalc.sv
`timescale 1ns/1ps
`default_nettype none

module channelCalc
    import batchPkg::*;
#(
    parameter int chanIdx = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     batchStart,
    input  ctrlBitsT lookSample,
    input  ctrlBitsT calcFwdSample,
    input  ctrlBitsT calcBwdSample,
    output fixT      fwdPart,
    output fixT      bwdPart
);

    complexT    lookTerm;
    complexT    fwdTerm;
    complexT    bwdTerm;
    complexT    lookState;
    complexT    fwdState;
    complexT    bwdState;
    logic [2:0] startCnt;
    logic       fwdStart;

    coeffLut #(.chanIdx(chanIdx), .useForward(1'b0)) i_lookLut (
        .bits(lookSample),
        .term(lookTerm)
    );
    coeffLut #(.chanIdx(chanIdx), .useForward(1'b1)) i_fwdLut (
        .bits(calcFwdSample),
        .term(fwdTerm)
    );
    coeffLut #(.chanIdx(chanIdx), .useForward(1'b0)) i_bwdLut (
        .bits(calcBwdSample),
        .term(bwdTerm)
    );

    // Batch starts counted until batch 0 first reaches the calc bank
    always_ff @(posedge clk) begin
        if (!rst) begin
            startCnt <= '0;
        end else if (batchStart && (startCnt != 3'(NUM_BANKS))) begin
            startCnt <= startCnt + 3'd1;
        end
    end

    // Forward state starts from zero at sample 0 of batch 0, then never restarts
    assign fwdStart = batchStart && (startCnt == 3'(NUM_BANKS - 1));

    recursion #(.factorRe(lambdaRe[chanIdx]), .factorIm(lambdaIm[chanIdx])) i_lookRec (
        .clk(clk),
        .rst(rst),
        .start(batchStart),
        .seed('0),
        .term(lookTerm),
        .state(lookState)
    );

    recursion #(.factorRe(phiRe[chanIdx]), .factorIm(phiIm[chanIdx])) i_fwdRec (
        .clk(clk),
        .rst(rst),
        .start(fwdStart),
        .seed('0),
        .term(fwdTerm),
        .state(fwdState)
    );

    // At batchStart the lookahead still holds its end state of the last batch
    recursion #(.factorRe(lambdaRe[chanIdx]), .factorIm(lambdaIm[chanIdx])) i_bwdRec (
        .clk(clk),
        .rst(rst),
        .start(batchStart),
        .seed(lookState),
        .term(bwdTerm),
        .state(bwdState)
    );

    // Real part of the weighted state only
    always_ff @(posedge clk) begin
        fwdPart <= fixMul(fwdState.re, weightFwdRe[chanIdx])
                 - fixMul(fwdState.im, weightFwdIm[chanIdx]);
        bwdPart <= fixMul(bwdState.re, weightBwdRe[chanIdx])
                 - fixMul(bwdState.im, weightBwdIm[chanIdx]);
    end

endmodule

`default_nettype wire

//--- estimator/resultCombine.sv
`timescale 1ns/1ps
`default_nettype none

module resultCombine
    import batchPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  fixT       fwdSum,
    input  fixT       bwdSum,
    input  sampleIdxT sampleIdx,
    input  sampleIdxT sampleIdxRev,
    input  logic      parity,
    input  logic      outEnable,
    output estT       estOut,
    output logic      estValid
);

    typedef struct packed {
        logic      enable;
        logic      parity;
        sampleIdxT idx;
        sampleIdxT idxRev;
    } slotT;

    slotT dly [PIPE_LAT];
    slotT cur;
    fixT  fwdMem [2 * BATCH_DEPTH];
    fixT  bwdMem [2 * BATCH_DEPTH];
    fixT  fwdRd;
    fixT  bwdRd;
    logic rdValid;

    // Counter state delayed to match the channel pipeline
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < PIPE_LAT; i++) begin
                dly[i] <= '0;
            end
        end else begin
            dly[0] <= '{outEnable, parity, sampleIdx, sampleIdxRev};
            for (int i = 1; i < PIPE_LAT; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign cur = dly[PIPE_LAT-1];

    // Write the new half, read back the half of the previous batch
    // Backward sums come in reversed, so they go in at the reversed index
    always_ff @(posedge clk) begin
        fwdMem[{~cur.parity, cur.idx}]    <= fwdSum;
        bwdMem[{~cur.parity, cur.idxRev}] <= bwdSum;
        fwdRd  <= fwdMem[{cur.parity, cur.idx}];
        bwdRd  <= bwdMem[{cur.parity, cur.idx}];
        estOut <= fwdRd + bwdRd;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rdValid  <= 1'b0;
            estValid <= 1'b0;
        end else begin
            rdValid  <= cur.enable;
            estValid <= rdValid;
        end
    end

    // A valid estimate only ever reads halves that were written
    estKnown: assert property (@(posedge clk) disable iff (!rst)
        estValid |-> !$isunknown(estOut))
        else $error("valid estimate holds unknown bits");

endmodule

`default_nettype wire

//--- hw/batchTop.sv
`timescale 1ns/1ps
`default_nettype none

module batchTop
    import batchPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ctrlBitsT ctrlIn,
    output estT      estOut,
    output logic     estValid
);

    sampleIdxT sampleIdx;
    sampleIdxT sampleIdxRev;
    bankSelT   bankSel;
    logic      batchStart;
    logic      outEnable;
    ctrlBitsT  lookSample;
    ctrlBitsT  calcFwdSample;
    ctrlBitsT  calcBwdSample;
    fixT       fwdPart [NUM_CHAN];
    fixT       bwdPart [NUM_CHAN];
    fixT       fwdChain [NUM_CHAN];
    fixT       bwdChain [NUM_CHAN];

    batchCtrl i_batchCtrl (
        .clk(clk),
        .rst(rst),
        .sampleIdx(sampleIdx),
        .sampleIdxRev(sampleIdxRev),
        .bankSel(bankSel),
        .batchStart(batchStart),
        .outEnable(outEnable)
    );

    sampleRam i_sampleRam (
        .clk(clk),
        .ctrlIn(ctrlIn),
        .bankSel(bankSel),
        .sampleIdx(sampleIdx),
        .sampleIdxRev(sampleIdxRev),
        .lookSample(lookSample),
        .calcFwdSample(calcFwdSample),
        .calcBwdSample(calcBwdSample)
    );

    for (genvar c = 0; c < NUM_CHAN; c++) begin : genChan
        channelCalc #(.chanIdx(c)) i_channelCalc (
            .clk(clk),
            .rst(rst),
            .batchStart(batchStart),
            .lookSample(lookSample),
            .calcFwdSample(calcFwdSample),
            .calcBwdSample(calcBwdSample),
            .fwdPart(fwdPart[c]),
            .bwdPart(bwdPart[c])
        );

        // Channel sums, wrapping at 16 bits
        if (c == 0) begin : genHead
            assign fwdChain[c] = fwdPart[c];
            assign bwdChain[c] = bwdPart[c];
        end else begin : genLink
            assign fwdChain[c] = fwdChain[c-1] + fwdPart[c];
            assign bwdChain[c] = bwdChain[c-1] + bwdPart[c];
        end
    end

    resultCombine i_resultCombine (
        .clk(clk),
        .rst(rst),
        .fwdSum(fwdChain[NUM_CHAN-1]),
        .bwdSum(bwdChain[NUM_CHAN-1]),
        .sampleIdx(sampleIdx),
        .sampleIdxRev(sampleIdxRev),
        .parity(bankSel.prevCalcParity),
        .outEnable(outEnable),
        .estOut(estOut),
        .estValid(estValid)
    );

endmodule

`default_nettype wire

//--- dv/estimatorModel.svh
`ifndef ESTIMATOR_MODEL_SVH
`define ESTIMATOR_MODEL_SVH

// Every applied control vector, in arrival order
ctrlBitsT modelSamples [$];
// Forward weighted channel sum per sample
fixT      fwdWeighted [$];
// Estimates waiting for the DUT, in sample order
estT      expectedEst [$];
complexT  modelFwd [NUM_CHAN];

// Wide product, arithmetic shift, low 16 bits
function automatic fixT mulFix(fixT a, fixT b);
    longint full;
    full = longint'(a) * longint'(b);
    return fixT'(full >>> FRAC_BITS);
endfunction

// One recursion step: factor times state plus input term
function automatic complexT stepState(fixT facRe, fixT facIm, complexT s, complexT t);
    complexT n;
    n.re = mulFix(facRe, s.re) - mulFix(facIm, s.im) + t.re;
    n.im = mulFix(facRe, s.im) + mulFix(facIm, s.re) + t.im;
    return n;
endfunction

// Set 1 for the forward gammas, set 0 for lookahead and backward
function automatic complexT inputTerm(int set, int chan, ctrlBitsT v);
    complexT t;
    t = '0;
    for (int b = 0; b < NUM_CHAN; b++) begin
        if (v[b]) begin
            t.re = t.re + gammaRe[set][chan][b];
            t.im = t.im + gammaIm[set][chan][b];
        end else begin
            t.re = t.re - gammaRe[set][chan][b];
            t.im = t.im - gammaIm[set][chan][b];
        end
    end
    return t;
endfunction

function automatic fixT realWeighted(complexT s, fixT wRe, fixT wIm);
    return mulFix(s.re, wRe) - mulFix(s.im, wIm);
endfunction

function automatic void clearModel();
    modelSamples.delete();
    fwdWeighted.delete();
    expectedEst.delete();
    for (int c = 0; c < NUM_CHAN; c++) begin
        modelFwd[c] = '0;
    end
endfunction

// Backward pass of batch b, seeded by a lookahead over batch b+1
function automatic void finishBatch(int b);
    complexT s;
    fixT     bwdSum [BATCH_DEPTH];
    int      base;
    int      next;
    base = b * BATCH_DEPTH;
    next = base + BATCH_DEPTH;
    for (int j = 0; j < BATCH_DEPTH; j++) begin
        bwdSum[j] = '0;
    end
    for (int c = 0; c < NUM_CHAN; c++) begin
        s = '0;
        for (int j = BATCH_DEPTH - 1; j >= 0; j--) begin
            s = stepState(lambdaRe[c], lambdaIm[c], s, inputTerm(0, c, modelSamples[next + j]));
        end
        for (int j = BATCH_DEPTH - 1; j >= 0; j--) begin
            s = stepState(lambdaRe[c], lambdaIm[c], s, inputTerm(0, c, modelSamples[base + j]));
            bwdSum[j] = bwdSum[j] + realWeighted(s, weightBwdRe[c], weightBwdIm[c]);
        end
    end
    for (int j = 0; j < BATCH_DEPTH; j++) begin
        expectedEst.push_back(estT'(fwdWeighted[base + j] + bwdSum[j]));
    end
endfunction

function automatic void pushSample(ctrlBitsT v);
    fixT sum;
    int  n;
    modelSamples.push_back(v);
    sum = '0;
    for (int c = 0; c < NUM_CHAN; c++) begin
        modelFwd[c] = stepState(phiRe[c], phiIm[c], modelFwd[c], inputTerm(1, c, v));
        sum = sum + realWeighted(modelFwd[c], weightFwdRe[c], weightFwdIm[c]);
    end
    fwdWeighted.push_back(sum);
    n = modelSamples.size();
    // A batch is complete once its lookahead batch is in
    if ((n % BATCH_DEPTH == 0) && (n >= 2 * BATCH_DEPTH)) begin
        finishBatch(n / BATCH_DEPTH - 2);
    end
endfunction

`endif

//--- dv/tbBatchTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbBatchTop
    import batchPkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 4;
    localparam int TEST_BATCHES [NUM_TESTS] = '{12, 12, 6, 8};

    typedef enum logic {RANDOM_BITS, ONES_THEN_ZEROS} patternT;

    logic     clk = 1'b0;
    logic     rst;
    ctrlBitsT ctrlIn;
    estT      estOut;
    logic     estValid;

    `include "estimatorModel.svh"

    batchTop i_batchTop (
        .clk(clk),
        .rst(rst),
        .ctrlIn(ctrlIn),
        .estOut(estOut),
        .estValid(estValid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compareEst(input string name, input estT expected, input estT actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: estValid expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    function automatic ctrlBitsT nextVector(patternT pattern, int k);
        if (pattern == RANDOM_BITS) begin
            return ctrlBitsT'($urandom);
        end
        return (k < 8 * BATCH_DEPTH) ? '1 : '0;
    endfunction

    // Returns at the third reset edge, reset still low
    task automatic resetDut(input string name);
        @(posedge clk);
        #1;
        rst = 1'b0;
        ctrlIn = '0;
        @(posedge clk);
        @(negedge clk);
        compareFlag(name, 1'b0, estValid);
        repeat (2) @(posedge clk);
    endtask

    // A cut run stops early and leaves the DUT in mid-stream
    task automatic runTest(input string name, input int nBatches, input patternT pattern,
                           input int cutCycle);
        int       numCycles;
        int       needed;
        int       checked;
        bit       seenValid;
        ctrlBitsT vec;
        numCycles = (cutCycle > 0) ? cutCycle : (nBatches + 5) * BATCH_DEPTH;
        needed = (cutCycle > 0) ? BATCH_DEPTH : nBatches * BATCH_DEPTH;
        checked = 0;
        seenValid = 1'b0;
        clearModel();
        resetDut(name);
        for (int k = 0; k < numCycles; k++) begin
            #1;
            if (k == 0) begin
                rst = 1'b1;
            end
            vec = nextVector(pattern, k);
            ctrlIn = vec;
            pushSample(vec);
            @(negedge clk);
            // Quiet for the first batch, then no gaps once running
            if (k < BATCH_DEPTH) begin
                compareFlag(name, 1'b0, estValid);
            end else if (seenValid) begin
                compareFlag(name, 1'b1, estValid);
            end
            if (estValid) begin
                seenValid = 1'b1;
                if (expectedEst.size() == 0) begin
                    $display("%s: estimate arrived before the model had a value for it", name);
                    abortRun();
                end else begin
                    compareEst(name, expectedEst.pop_front(), estOut);
                    checked++;
                end
            end
            @(posedge clk);
        end
        if (checked < needed) begin
            $display("%s: only %0d estimates arrived, at least %0d were due", name, checked, needed);
            abortRun();
        end
        $display("%s: %0d estimates checked", name, checked);
    endtask

    function automatic int watchdogCycles();
        int cycles;
        cycles = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycles += (TEST_BATCHES[i] + 5) * BATCH_DEPTH;
        end
        return cycles;
    endfunction

    initial begin
        int limitNs;
        limitNs = 2 * watchdogCycles() * CLK_PERIOD;
        #(limitNs);
        $display("Watchdog expired after %0d ns before all tests finished", limitNs);
        $display("test failed");
        $fatal(1);
    end

    initial begin
        rst = 1'b0;
        ctrlIn = '0;
        void'($urandom(32'he951));
        runTest("randomRun", TEST_BATCHES[0], RANDOM_BITS, 0);
        runTest("onesThenZeros", TEST_BATCHES[1], ONES_THEN_ZEROS, 0);
        // Cut in the middle of batch 7
        runTest("midRunReset", TEST_BATCHES[2], RANDOM_BITS, 7 * BATCH_DEPTH + 7);
        runTest("afterReset", TEST_BATCHES[3], RANDOM_BITS, 0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+dv
common/batchPkg.sv
hw/batchCtrl.sv
hw/sampleRam.sv
hw/coeffLut.sv
hw/recursion.sv
estimator/channelCalc.sv
estimator/resultCombine.sv
hw/batchTop.sv
dv/tbBatchTop.sv

//--- run.sh
#!/bin/sh
# Build and run the estimator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tbBatchTop -o simv -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
